// File: rtl/ls_macros.svh
// ==============================
// Width and depth constants for the load streamer
// Included by the package and by every RTL module
// ==============================

`ifndef LS_MACROS_SVH
`define LS_MACROS_SVH

// Byte address and memory word widths
`define LS_ADDR_W 32
`define LS_DATA_W 32

// Output lane width and word counter width
`define LS_LANE_W 16
`define LS_LEN_W 16

// Load FIFO depth, enough for a consumer that needs two beats per word
`define LS_FIFO_DEPTH 4

// Occupancy counter width, holds 0 up to LS_FIFO_DEPTH
`define LS_CNT_W ($clog2(`LS_FIFO_DEPTH) + 1)

`endif

// File: rtl/ls_pkg.sv
// ==============================
// Types shared by the load streamer RTL and its testbench
// ==============================

`default_nettype none

`include "ls_macros.svh"

package ls_pkg;

  // Input format of the words in memory
  typedef enum logic {
    FMT_INT16 = 1'b0,
    FMT_INT8  = 1'b1
  } ls_fmt_e;

  // Job description, held stable from start until done
  typedef struct packed {
    logic [`LS_ADDR_W-1:0] base_addr;
    logic [`LS_ADDR_W-1:0] stride;
    logic [`LS_LEN_W-1:0]  len;
    ls_fmt_e               fmt;
  } ls_ctrl_t;

  typedef struct packed {
    logic busy;
    logic done;
  } ls_flags_t;

  // Memory port, request side and response side
  typedef struct packed {
    logic                  req;
    logic [`LS_ADDR_W-1:0] addr;
  } ls_mem_req_t;

  typedef struct packed {
    logic                  r_valid;
    logic [`LS_DATA_W-1:0] r_data;
  } ls_mem_rsp_t;

  // One memory word seen as two 16-bit halves or four bytes
  typedef union packed {
    logic [1:0][`LS_LANE_W-1:0] halves;
    logic [3:0][7:0]            bytes;
  } ls_word_u;

  // Stream beat, lane0 sits in the low bits
  typedef struct packed {
    logic signed [`LS_LANE_W-1:0] lane1;
    logic signed [`LS_LANE_W-1:0] lane0;
  } ls_beat_t;

endpackage

`default_nettype wire

// File: rtl/ls_addr_gen.sv
// ==============================
// Strided read producer for the load FIFO
// Issues one request per word while the FIFO has credit
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "ls_macros.svh"

module ls_addr_gen (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  ls_pkg::ls_ctrl_t     ctrl_i,
  input  logic [`LS_CNT_W-1:0] fifo_count_i,
  output ls_pkg::ls_mem_req_t  mem_req_o,
  input  logic                 mem_gnt_i,
  input  logic                 rsp_valid_i,
  input  logic                 done_i,
  output logic                 busy_o
);

  logic [`LS_ADDR_W-1:0] addr_q;
  logic [`LS_LEN_W-1:0]  to_issue_q;
  logic [`LS_CNT_W-1:0]  inflight_q;
  logic [`LS_CNT_W:0]    used;
  logic                  busy_q;
  logic                  credit_ok;
  logic                  req;
  logic                  grant;

  // Words already stored plus words still on their way back
  assign used      = {1'b0, fifo_count_i} + {1'b0, inflight_q};
  assign credit_ok = (used < `LS_FIFO_DEPTH);

  // Credit never shrinks while req waits, so addr is held until gnt
  assign req   = busy_q && (to_issue_q != '0) && credit_ok;
  assign grant = req && mem_gnt_i;

  assign mem_req_o.req  = req;
  assign mem_req_o.addr = addr_q;
  assign busy_o         = busy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      to_issue_q <= '0;
      inflight_q <= '0;
    end else if (clear_i) begin
      busy_q     <= 1'b0;
      to_issue_q <= '0;
      inflight_q <= '0;
    end else begin
      if (start_i) begin
        busy_q     <= 1'b1;
        to_issue_q <= ctrl_i.len;
      end else begin
        // Busy lasts until the consumer has sent its last beat
        if (done_i) begin
          busy_q <= 1'b0;
        end
        if (grant) begin
          to_issue_q <= to_issue_q - 1'b1;
        end
      end

      // Responses come back exactly one cycle after each grant
      case ({grant, rsp_valid_i})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  // Next word address
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= ctrl_i.base_addr;
    end else if (grant) begin
      addr_q <= addr_q + ctrl_i.stride;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ls_load_fifo.sv
// ==============================
// Circular buffer for read responses
// Written on r_valid, popped by the cast stage
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "ls_macros.svh"

module ls_load_fifo (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  clear_i,
  input  logic                  push_i,
  input  logic [`LS_DATA_W-1:0] push_data_i,
  input  logic                  pop_i,
  output ls_pkg::ls_word_u      data_o,
  output logic                  empty_o,
  output logic [`LS_CNT_W-1:0]  count_o
);

  import ls_pkg::*;

  localparam int unsigned PTR_W = $clog2(`LS_FIFO_DEPTH);

  ls_word_u             mem_q [`LS_FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [`LS_CNT_W-1:0] count_q;

  // Wraps at the last entry, so any depth works
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`LS_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Head is read straight from storage
  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ls_castin.sv
// ==============================
// Cast stage from FIFO words to two-lane stream beats
// INT16 gives one beat per word, INT8 gives two
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "ls_macros.svh"

module ls_castin (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             clear_i,
  input  logic             start_i,
  input  ls_pkg::ls_ctrl_t ctrl_i,
  input  ls_pkg::ls_word_u word_i,
  input  logic             empty_i,
  output logic             pop_o,
  output ls_pkg::ls_beat_t stream_o,
  output logic             stream_valid_o,
  input  logic             stream_ready_i,
  output logic             done_o
);

  import ls_pkg::*;

  logic [`LS_LEN_W-1:0] words_left_q;
  logic                 beat_sel_q;
  logic                 done_q;
  logic                 last_beat;
  logic                 xfer;
  logic [7:0]           byte_lo;
  logic [7:0]           byte_hi;
  ls_beat_t             beat;

  // Byte pair 0/1 first, then 2/3
  assign byte_lo = word_i.bytes[{beat_sel_q, 1'b0}];
  assign byte_hi = word_i.bytes[{beat_sel_q, 1'b1}];

  always_comb begin
    if (ctrl_i.fmt == FMT_INT16) begin
      beat.lane0 = word_i.halves[0];
      beat.lane1 = word_i.halves[1];
    end else begin
      beat.lane0 = {{(`LS_LANE_W - 8){byte_lo[7]}}, byte_lo};
      beat.lane1 = {{(`LS_LANE_W - 8){byte_hi[7]}}, byte_hi};
    end
  end

  assign stream_o       = beat;
  assign stream_valid_o = !empty_i && (words_left_q != '0);
  assign xfer           = stream_valid_o && stream_ready_i;

  // The head word leaves the FIFO with its final beat
  assign last_beat = (ctrl_i.fmt == FMT_INT16) || beat_sel_q;
  assign pop_o     = xfer && last_beat;
  assign done_o    = done_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      words_left_q <= '0;
      beat_sel_q   <= 1'b0;
      done_q       <= 1'b0;
    end else if (clear_i) begin
      words_left_q <= '0;
      beat_sel_q   <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      done_q <= pop_o && (words_left_q == `LS_LEN_W'(1));
      if (start_i) begin
        words_left_q <= ctrl_i.len;
        beat_sel_q   <= 1'b0;
      end else if (xfer) begin
        // Stays at zero in INT16, toggles in INT8
        beat_sel_q <= !last_beat;
        if (last_beat) begin
          words_left_q <= words_left_q - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/ls_load_streamer.sv
// ==============================
// Load streamer top level
// Address producer, load FIFO and cast stage in a row
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "ls_macros.svh"

module ls_load_streamer (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                clear_i,
  input  logic                start_i,
  input  ls_pkg::ls_ctrl_t    ctrl_i,
  output ls_pkg::ls_mem_req_t mem_req_o,
  input  logic                mem_gnt_i,
  input  ls_pkg::ls_mem_rsp_t mem_rsp_i,
  output ls_pkg::ls_beat_t    stream_o,
  output logic                stream_valid_o,
  input  logic                stream_ready_i,
  output ls_pkg::ls_flags_t   flags_o
);

  import ls_pkg::*;

  ls_word_u             fifo_word;
  logic                 fifo_empty;
  logic [`LS_CNT_W-1:0] fifo_count;
  logic                 fifo_pop;
  logic                 busy;
  logic                 done;

  assign flags_o.busy = busy;
  assign flags_o.done = done;

  ls_addr_gen i_addr_gen (
    .clk_i        ( clk_i             ),
    .rst_n_i      ( rst_n_i           ),
    .clear_i      ( clear_i           ),
    .start_i      ( start_i           ),
    .ctrl_i       ( ctrl_i            ),
    .fifo_count_i ( fifo_count        ),
    .mem_req_o    ( mem_req_o         ),
    .mem_gnt_i    ( mem_gnt_i         ),
    .rsp_valid_i  ( mem_rsp_i.r_valid ),
    .done_i       ( done              ),
    .busy_o       ( busy              )
  );

  // Responses go straight into the FIFO
  ls_load_fifo i_load_fifo (
    .clk_i       ( clk_i             ),
    .rst_n_i     ( rst_n_i           ),
    .clear_i     ( clear_i           ),
    .push_i      ( mem_rsp_i.r_valid ),
    .push_data_i ( mem_rsp_i.r_data  ),
    .pop_i       ( fifo_pop          ),
    .data_o      ( fifo_word         ),
    .empty_o     ( fifo_empty        ),
    .count_o     ( fifo_count        )
  );

  ls_castin i_castin (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .clear_i        ( clear_i        ),
    .start_i        ( start_i        ),
    .ctrl_i         ( ctrl_i         ),
    .word_i         ( fifo_word      ),
    .empty_i        ( fifo_empty     ),
    .pop_o          ( fifo_pop       ),
    .stream_o       ( stream_o       ),
    .stream_valid_o ( stream_valid_o ),
    .stream_ready_i ( stream_ready_i ),
    .done_o         ( done           )
  );

endmodule

`default_nettype wire

// File: verif/ls_clk_gen.sv
// ==============================
// Testbench clock and power-on reset
// ==============================

`timescale 1ns/1ps
`default_nettype none

module ls_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Reset held for four rising edges, released just after the last one
  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #10;
    rst_n_o = 1'b1;
  end

  always #50 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: verif/ls_props.sv
// ==============================
// Interface assertions for the load streamer
// Bound to the top level by the testbench
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "ls_macros.svh"

module ls_props (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input ls_pkg::ls_mem_req_t   mem_req_i,
  input logic                  mem_gnt_i,
  input logic                  r_valid_i,
  input logic [`LS_CNT_W-1:0]  fifo_count_i,
  input ls_pkg::ls_beat_t      stream_i,
  input logic                  stream_valid_i,
  input logic                  stream_ready_i,
  input logic                  done_i
);

  // Number of assertion failures so far
  int fail_cnt = 0;

  // One cycle of memory latency, so r_valid marks the only read in flight
  a_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i.req |-> ({1'b0, fifo_count_i} + {`LS_CNT_W'(0), r_valid_i}) < `LS_FIFO_DEPTH)
    else begin
      $error("read request issued with no FIFO credit left");
      fail_cnt++;
    end

  a_addr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i.req && !mem_gnt_i |=> mem_req_i.req && $stable(mem_req_i.addr))
    else begin
      $error("request dropped or address changed before grant");
      fail_cnt++;
    end

  a_beat_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stream_valid_i && !stream_ready_i |=> stream_valid_i && $stable(stream_i))
    else begin
      $error("stream beat not held under back-pressure");
      fail_cnt++;
    end

  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |=> !done_i)
    else begin
      $error("done held for more than one cycle");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// File: verif/ls_mem_word.svh
// ==============================
// Memory image used by the testbench responder and checker
// Included inside a module body
// ==============================

// Every address bit reaches the word, and the top bit of each byte is set often
function automatic logic [31:0] mem_word(input logic [31:0] addr);
  return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
endfunction

// File: verif/ls_checker.sv
// ==============================
// Scoreboard for the load streamer stream and flags
// Expected beats are built on start and compared on every transfer
// ==============================

`timescale 1ns/1ps
`default_nettype none

module ls_checker (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              start_i,
  input  ls_pkg::ls_ctrl_t  ctrl_i,
  input  ls_pkg::ls_beat_t  stream_i,
  input  logic              stream_valid_i,
  input  logic              stream_ready_i,
  input  ls_pkg::ls_flags_t flags_i,
  output int                errors_o
);

  import ls_pkg::*;

  ls_beat_t    exp_q[$];
  ls_beat_t    exp_beat;
  int unsigned n_beats;
  int          err_cnt  = 0;
  logic        done_due = 1'b0;
  logic        busy_exp = 1'b0;

  `include "ls_mem_word.svh"

  assign errors_o = err_cnt;

  // Beat k of a job: INT16 takes both halves, INT8 a sign-extended byte pair
  function automatic ls_beat_t ref_beat(input ls_ctrl_t c, input int unsigned k);
    logic [31:0] w;
    logic [15:0] pair;
    ls_beat_t    b;
    if (c.fmt == FMT_INT16) begin
      w       = mem_word(c.base_addr + k * c.stride);
      b.lane0 = w[15:0];
      b.lane1 = w[31:16];
    end else begin
      w       = mem_word(c.base_addr + (k / 2) * c.stride);
      pair    = (k % 2 == 0) ? w[15:0] : w[31:16];
      b.lane0 = {{8{pair[7]}}, pair[7:0]};
      b.lane1 = {{8{pair[15]}}, pair[15:8]};
    end
    return b;
  endfunction

  // Mid-cycle sampling, all DUT outputs and driven inputs are settled
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      exp_q.delete();
      done_due = 1'b0;
      busy_exp = 1'b0;
    end else begin
      if (flags_i.done !== done_due) begin
        $display("mismatch at %0t: flags_o.done expected %0b got %0b",
                 $time, done_due, flags_i.done);
        err_cnt++;
      end
      if (flags_i.busy !== busy_exp) begin
        $display("mismatch at %0t: flags_o.busy expected %0b got %b",
                 $time, busy_exp, flags_i.busy);
        err_cnt++;
      end
      // Busy rises after start and falls after the expected done
      if (start_i) begin
        busy_exp = 1'b1;
      end else if (done_due) begin
        busy_exp = 1'b0;
      end
      done_due = 1'b0;
      if (start_i) begin
        exp_q.delete();
        n_beats = (ctrl_i.fmt == FMT_INT8) ? 2 * ctrl_i.len : ctrl_i.len;
        for (int unsigned k = 0; k < n_beats; k++) begin
          exp_q.push_back(ref_beat(ctrl_i, k));
        end
      end
      if (stream_valid_i && stream_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t: a beat was transferred when none was expected", $time);
          err_cnt++;
        end else begin
          exp_beat = exp_q.pop_front();
          if (stream_i !== exp_beat) begin
            $display("mismatch at %0t: stream_o expected %h got %h",
                     $time, exp_beat, stream_i);
            err_cnt++;
          end
          done_due = (exp_q.size() == 0);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/ls_tb.sv
// ==============================
// Testbench top for the load streamer
// Runs a series of jobs against a random-grant memory model
// ==============================

`timescale 1ns/1ps
`default_nettype none

module ls_tb;

  import ls_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        clear        = 1'b0;
  logic        start        = 1'b0;
  ls_ctrl_t    ctrl         = '0;
  ls_mem_req_t mem_req;
  logic        mem_gnt      = 1'b0;
  ls_mem_rsp_t mem_rsp      = '0;
  ls_beat_t    stream;
  logic        stream_valid;
  logic        stream_ready = 1'b0;
  ls_flags_t   flags;
  int          chk_errors;
  int          tb_errors    = 0;
  integer      seed         = 32'h21c30bf1;
  int          gnt_pct      = 100;
  int          ready_pct    = 100;
  logic        granted      = 1'b0;
  logic [31:0] granted_addr = '0;
  logic        timed_out    = 1'b0;

  `include "ls_mem_word.svh"

  ls_clk_gen u_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  ls_load_streamer DUT (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .clear_i        ( clear        ),
    .start_i        ( start        ),
    .ctrl_i         ( ctrl         ),
    .mem_req_o      ( mem_req      ),
    .mem_gnt_i      ( mem_gnt      ),
    .mem_rsp_i      ( mem_rsp      ),
    .stream_o       ( stream       ),
    .stream_valid_o ( stream_valid ),
    .stream_ready_i ( stream_ready ),
    .flags_o        ( flags        )
  );

  ls_checker u_checker (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .start_i        ( start        ),
    .ctrl_i         ( ctrl         ),
    .stream_i       ( stream       ),
    .stream_valid_i ( stream_valid ),
    .stream_ready_i ( stream_ready ),
    .flags_i        ( flags        ),
    .errors_o       ( chk_errors   )
  );

  bind ls_load_streamer ls_props u_props (
    .clk_i          ( clk_i             ),
    .rst_n_i        ( rst_n_i           ),
    .mem_req_i      ( mem_req_o         ),
    .mem_gnt_i      ( mem_gnt_i         ),
    .r_valid_i      ( mem_rsp_i.r_valid ),
    .fifo_count_i   ( fifo_count        ),
    .stream_i       ( stream_o          ),
    .stream_valid_i ( stream_valid_o    ),
    .stream_ready_i ( stream_ready_i    ),
    .done_i         ( flags_o.done      )
  );

  function automatic logic chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // Memory responder, a grant seen mid-cycle is answered in the next cycle
  always @(negedge clk) begin
    granted      = mem_req.req && mem_gnt;
    granted_addr = mem_req.addr;
  end

  always @(posedge clk) begin
    #10;
    mem_rsp.r_valid = granted;
    mem_rsp.r_data  = granted ? mem_word(granted_addr) : '0;
    mem_gnt         = chance(gnt_pct);
    stream_ready    = chance(ready_pct);
  end

  task automatic wait_reset();
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("Error: reset was not released within 20 cycles");
      timed_out = 1'b1;
    end
  endtask

  task automatic expect_low(input string name, input logic value);
    if (value !== 1'b0) begin
      $display("mismatch at %0t: %s expected 0 got %b", $time, name, value);
      tb_errors++;
    end
  endtask

  task automatic check_idle();
    repeat (3) begin
      @(negedge clk);
      expect_low("mem_req_o.req", mem_req.req);
      expect_low("stream_valid_o", stream_valid);
      expect_low("flags_o.busy", flags.busy);
      expect_low("flags_o.done", flags.done);
    end
  endtask

  task automatic run_job(input logic [31:0] base, input logic [31:0] stride,
                         input logic [15:0] len, input ls_fmt_e fmt,
                         input int r_pct, input int g_pct);
    int n;
    if (timed_out) begin
      return;
    end
    @(posedge clk);
    ready_pct = r_pct;
    gnt_pct   = g_pct;
    #10;
    ctrl.base_addr = base;
    ctrl.stride    = stride;
    ctrl.len       = len;
    ctrl.fmt       = fmt;
    start          = 1'b1;
    @(posedge clk);
    #10;
    start = 1'b0;
    n     = 0;
    @(negedge clk);
    while (flags.done !== 1'b1 && n < 2000) begin
      @(negedge clk);
      n++;
    end
    if (flags.done !== 1'b1) begin
      $display("Error: no done within 2000 cycles of start at base %h", base);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    wait_reset();
    if (!timed_out) begin
      check_idle();
    end
    run_job(32'h0000_1000, 32'd4, 16'd8, FMT_INT16, 100, 100);
    run_job(32'h0000_2000, 32'd8, 16'd6, FMT_INT8, 100, 100);
    run_job(32'h0000_3000, 32'd12, 16'd10, FMT_INT16, 40, 100);
    run_job(32'h0000_4000, 32'd8, 16'd7, FMT_INT8, 100, 35);
    run_job(32'h8000_0000, 32'd4, 16'd12, FMT_INT8, 50, 50);
    // Let the checker see the idle cycle after the last done
    repeat (3) @(negedge clk);
    @(posedge clk);
    $display("Errors: %0d testbench, %0d checker, %0d assertion, %0d timeout",
             tb_errors, chk_errors, DUT.u_props.fail_cnt, timed_out);
    if (tb_errors == 0 && chk_errors == 0 && DUT.u_props.fail_cnt == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: load_streamer.f
+incdir+rtl
+incdir+verif
rtl/ls_pkg.sv
rtl/ls_addr_gen.sv
rtl/ls_load_fifo.sv
rtl/ls_castin.sv
rtl/ls_load_streamer.sv
verif/ls_clk_gen.sv
verif/ls_props.sv
verif/ls_checker.sv
verif/ls_tb.sv

// File: Makefile
# Verilator simulation of the load streamer

VERILATOR ?= verilator
TOP       ?= ls_tb
FLIST     ?= load_streamer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
	  echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "Test OK" $(LOG); then \
	  echo "FAIL: no result line in $(LOG)"; exit 1; \
	fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
